// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= memUartBridgeTb
FILELIST  ?= memUartBridge.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== hdl/busMerge.sv ====
`timescale 1ns/1ps

module busMerge
	import memBusPkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  memReq                req,
	output logic                 sramGo,
	output logic                 uartGo,
	output logic                 isWrite,
	input  logic                 sramCapture,
	input  logic                 sramDrive,
	input  logic                 sramFinished,
	input  logic                 uartCapture,
	input  logic                 uartDrive,
	input  logic                 uartFinished,
	input  logic [dataWidth-1:0] busIn,
	output logic [dataWidth-1:0] busOut,
	output logic                 busOe,
	output logic [addrWidth-1:0] addr,
	output logic [dataWidth-1:0] result,
	output logic                 done
);

	typedef enum logic [2:0] {
		reqNone,
		reqSramRead,
		reqSramWrite,
		reqUartRead,
		reqUartWrite
	} reqKind;

	reqKind               kind;
	logic                 busy;
	logic                 accept;
	logic [dataWidth-1:0] value;

	// Write wins over read on the UART address
	always_comb begin
		kind = reqNone;
		if (req.addr == uartAddr) begin
			if (req.wr) begin
				kind = reqUartWrite;
			end else if (req.rd) begin
				kind = reqUartRead;
			end
		end else begin
			kind = req.wr ? reqSramWrite : reqSramRead;
		end
	end

	assign accept = req.start && !busy && (kind != reqNone);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy    <= 1'b0;
			sramGo  <= 1'b0;
			uartGo  <= 1'b0;
			isWrite <= 1'b0;
			done    <= 1'b0;
			result  <= '0;
		end else begin
			sramGo <= accept && (kind == reqSramRead || kind == reqSramWrite);
			uartGo <= accept && (kind == reqUartRead || kind == reqUartWrite);
			if (accept) begin
				busy    <= 1'b1;
				done    <= 1'b0;
				isWrite <= (kind == reqSramWrite || kind == reqUartWrite);
			end else if (sramFinished || uartFinished) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
			if (sramCapture) begin
				result <= busIn;
			end else if (uartCapture) begin
				result <= {{(dataWidth - byteWidth){1'b0}}, busIn[byteWidth-1:0]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr  <= req.addr;
			value <= req.value;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Shared data bus
	//////////////////////////////////////////////////////////////////////

	assign busOe  = sramDrive | uartDrive;
	assign busOut = uartDrive ? {{(dataWidth - byteWidth){1'b0}}, value[byteWidth-1:0]} : value;

endmodule

// ==== hdl/memBusPkg.sv ====
package memBusPkg;

	//////////////////////////////////////////////////////////////////////
	// Shared bus geometry
	//////////////////////////////////////////////////////////////////////

	// One word per address
	localparam int addrWidth = 18;
	localparam int dataWidth = 16;

	// UART chip only uses the low byte lane
	localparam int byteWidth = 8;

	// The single address decoded as the UART data register
	localparam logic [addrWidth-1:0] uartAddr = 18'h0BF00;

	typedef logic [addrWidth-1:0] memAddr;
	typedef logic [dataWidth-1:0] memWord;

	//////////////////////////////////////////////////////////////////////
	// Processor side request
	//////////////////////////////////////////////////////////////////////

	// Sampled only when the bridge is idle
	typedef struct packed {
		logic   start;
		logic   rd;
		logic   wr;
		memAddr addr;
		memWord value;
	} memReq;

endpackage

// ==== hdl/memUartBridge.sv ====
`timescale 1ns/1ps

module memUartBridge
	import memBusPkg::*;
	import portCtrlPkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  memReq                req,
	input  uartFlags             flags,
	input  logic [dataWidth-1:0] busIn,
	output logic [dataWidth-1:0] busOut,
	output logic                 busOe,
	output logic [addrWidth-1:0] addr,
	output sramCtrl              sram,
	output uartCtrl              uart,
	output logic [dataWidth-1:0] result,
	output logic                 done
);

	logic sramGo;
	logic uartGo;
	logic isWrite;
	logic sramCapture;
	logic sramDrive;
	logic sramFinished;
	logic uartCapture;
	logic uartDrive;
	logic uartFinished;

	sramPort sramPort_inst (
		.clk      (clk),
		.rst      (rst),
		.go       (sramGo),
		.isWrite  (isWrite),
		.ctrl     (sram),
		.capture  (sramCapture),
		.driveBus (sramDrive),
		.finished (sramFinished)
	);

	uartPort uartPort_inst (
		.clk      (clk),
		.rst      (rst),
		.go       (uartGo),
		.isWrite  (isWrite),
		.flags    (flags),
		.ctrl     (uart),
		.capture  (uartCapture),
		.driveBus (uartDrive),
		.finished (uartFinished)
	);

	busMerge busMerge_inst (
		.clk          (clk),
		.rst          (rst),
		.req          (req),
		.sramGo       (sramGo),
		.uartGo       (uartGo),
		.isWrite      (isWrite),
		.sramCapture  (sramCapture),
		.sramDrive    (sramDrive),
		.sramFinished (sramFinished),
		.uartCapture  (uartCapture),
		.uartDrive    (uartDrive),
		.uartFinished (uartFinished),
		.busIn        (busIn),
		.busOut       (busOut),
		.busOe        (busOe),
		.addr         (addr),
		.result       (result),
		.done         (done)
	);

endmodule

// ==== hdl/portCtrlPkg.sv ====
package portCtrlPkg;

	//////////////////////////////////////////////////////////////////////
	// Sequencer states
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		sramIdle,
		sramReadAddr,
		sramReadWait,
		sramReadCapture,
		sramWriteAddr,
		sramWritePulse,
		sramWriteHold
	} sramState;

	typedef enum logic [3:0] {
		uartIdle,
		uartReadWaitReady,
		uartReadStrobe,
		uartReadCapture,
		uartWriteLoad,
		uartWritePulse,
		uartWriteWaitBuffer,
		uartWriteWaitShift,
		uartWriteFinish
	} uartState;

	//////////////////////////////////////////////////////////////////////
	// Chip pins
	//////////////////////////////////////////////////////////////////////

	// All strobes active low
	typedef struct packed {
		logic en;
		logic oe;
		logic we;
	} sramCtrl;

	typedef struct packed {
		logic rdn;
		logic wrn;
	} uartCtrl;

	// Status pins from the UART chip, active high
	typedef struct packed {
		logic dataReady;
		logic tbre;
		logic tsre;
	} uartFlags;

endpackage

// ==== hdl/sramPort.sv ====
`timescale 1ns/1ps

module sramPort
	import portCtrlPkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    go,
	input  logic    isWrite,
	output sramCtrl ctrl,
	output logic    capture,
	output logic    driveBus,
	output logic    finished
);

	sramState state;
	sramState nextState;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= sramIdle;
		end else begin
			state <= nextState;
		end
	end

	// Fixed three-cycle access in both directions
	always_comb begin
		nextState = state;
		case (state)
			sramIdle: begin
				if (go) begin
					nextState = isWrite ? sramWriteAddr : sramReadAddr;
				end
			end
			sramReadAddr:    nextState = sramReadWait;
			sramReadWait:    nextState = sramReadCapture;
			sramReadCapture: nextState = sramIdle;
			sramWriteAddr:   nextState = sramWritePulse;
			sramWritePulse:  nextState = sramWriteHold;
			sramWriteHold:   nextState = sramIdle;
			default:         nextState = sramIdle;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Strobe decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		ctrl     = '{en: 1'b1, oe: 1'b1, we: 1'b1};
		capture  = 1'b0;
		driveBus = 1'b0;
		finished = 1'b0;
		case (state)
			sramReadAddr, sramReadWait: begin
				ctrl.en = 1'b0;
				ctrl.oe = 1'b0;
			end
			sramReadCapture: begin
				ctrl.en  = 1'b0;
				ctrl.oe  = 1'b0;
				capture  = 1'b1;
				finished = 1'b1;
			end
			sramWriteAddr: begin
				ctrl.en  = 1'b0;
				driveBus = 1'b1;
			end
			sramWritePulse: begin
				// Data already settled on the bus
				ctrl.en  = 1'b0;
				ctrl.we  = 1'b0;
				driveBus = 1'b1;
			end
			sramWriteHold: begin
				ctrl.en  = 1'b0;
				driveBus = 1'b1;
				finished = 1'b1;
			end
			default: begin
				ctrl = '{en: 1'b1, oe: 1'b1, we: 1'b1};
			end
		endcase
	end

endmodule

// ==== hdl/uartPort.sv ====
`timescale 1ns/1ps

module uartPort
	import portCtrlPkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     go,
	input  logic     isWrite,
	input  uartFlags flags,
	output uartCtrl  ctrl,
	output logic     capture,
	output logic     driveBus,
	output logic     finished
);

	uartState state;
	uartState nextState;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= uartIdle;
		end else begin
			state <= nextState;
		end
	end

	// Latency depends on the chip flags
	always_comb begin
		nextState = state;
		case (state)
			uartIdle: begin
				if (go) begin
					nextState = isWrite ? uartWriteLoad : uartReadWaitReady;
				end
			end
			uartReadWaitReady: begin
				if (flags.dataReady) begin
					nextState = uartReadStrobe;
				end
			end
			uartReadStrobe:  nextState = uartReadCapture;
			uartReadCapture: nextState = uartIdle;
			uartWriteLoad:   nextState = uartWritePulse;
			uartWritePulse:  nextState = uartWriteWaitBuffer;
			uartWriteWaitBuffer: begin
				if (flags.tbre) begin
					nextState = uartWriteWaitShift;
				end
			end
			uartWriteWaitShift: begin
				// Transmitter fully drained
				if (flags.tsre) begin
					nextState = uartWriteFinish;
				end
			end
			uartWriteFinish: nextState = uartIdle;
			default:         nextState = uartIdle;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Strobe decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		ctrl     = '{rdn: 1'b1, wrn: 1'b1};
		capture  = 1'b0;
		driveBus = 1'b0;
		finished = 1'b0;
		case (state)
			uartReadStrobe: begin
				// Byte is valid while rdn is low, result loads on the way out
				ctrl.rdn = 1'b0;
				capture  = 1'b1;
			end
			uartReadCapture: begin
				finished = 1'b1;
			end
			uartWriteLoad, uartWriteWaitBuffer, uartWriteWaitShift: begin
				driveBus = 1'b1;
			end
			uartWritePulse: begin
				ctrl.wrn = 1'b0;
				driveBus = 1'b1;
			end
			uartWriteFinish: begin
				driveBus = 1'b1;
				finished = 1'b1;
			end
			default: begin
				ctrl = '{rdn: 1'b1, wrn: 1'b1};
			end
		endcase
	end

endmodule

// ==== memUartBridge.f ====
hdl/memBusPkg.sv
hdl/portCtrlPkg.sv
hdl/sramPort.sv
hdl/uartPort.sv
hdl/busMerge.sv
hdl/memUartBridge.sv
testbench/busModels.sv
testbench/memUartBridgeTb.sv

// ==== testbench/busModels.sv ====
`timescale 1ns/1ps

module busModels
	import memBusPkg::*;
	import portCtrlPkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  memWord               busOut,
	input  logic                 busOe,
	input  memAddr               addr,
	input  sramCtrl              sram,
	input  uartCtrl              uart,
	input  logic                 rxPush,
	input  logic [byteWidth-1:0] rxByte,
	output memWord               busIn,
	output uartFlags             flags,
	output int                   txCount,
	output logic [byteWidth-1:0] txLast
);

	localparam int memDepth = 1 << addrWidth;

	memWord               mem [memDepth];
	logic [byteWidth-1:0] rxQueue[$];
	logic [byteWidth-1:0] txLog[$];
	logic [byteWidth-1:0] rxHead;
	logic                 sramDrive;
	int                   readyDelay;
	int                   tbreDelay;
	int                   tsreDelay;

	//////////////////////////////////////////////////////////////////////
	// SRAM chip
	//////////////////////////////////////////////////////////////////////

	// Power-up contents mix in every address bit
	initial begin
		memAddr a;
		for (int i = 0; i < memDepth; i++) begin
			a = memAddr'(i);
			mem[a] = a[dataWidth-1:0] ^
				{a[addrWidth-1:dataWidth], a[dataWidth-1:addrWidth-dataWidth]};
		end
	end

	always @(posedge sram.we) begin
		if (!sram.en) begin
			mem[addr] <= busIn;
		end
	end

	assign sramDrive = !sram.en && !sram.oe;

	// Lines nobody drives float high, the UART only drives the low byte
	assign busIn = busOe ? busOut :
		sramDrive ? mem[addr] :
		!uart.rdn ? {{(dataWidth - byteWidth){1'b1}}, rxHead} :
		'1;

	//////////////////////////////////////////////////////////////////////
	// UART chip
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			flags      <= '{dataReady: 1'b0, tbre: 1'b1, tsre: 1'b1};
			readyDelay <= 0;
			tbreDelay  <= 0;
			tsreDelay  <= 0;
			txCount    <= 0;
			txLast     <= '0;
			rxHead     <= '0;
			rxQueue.delete();
			txLog.delete();
		end else begin
			// Byte leaves the receive buffer as rdn rises
			if (!uart.rdn) begin
				void'(rxQueue.pop_front());
				flags.dataReady <= 1'b0;
				readyDelay      <= 1 + $urandom_range(7);
			end else if (!flags.dataReady && rxQueue.size() > 0) begin
				if (readyDelay == 0) begin
					flags.dataReady <= 1'b1;
				end else begin
					readyDelay <= readyDelay - 1;
				end
			end
			if (rxPush) begin
				rxQueue.push_back(rxByte);
				readyDelay <= 1 + $urandom_range(7);
			end
			rxHead <= (rxQueue.size() > 0) ? rxQueue[0] : '0;

			// Transmitter drains the holding register, then the shift register
			if (!uart.wrn) begin
				txLog.push_back(busIn[byteWidth-1:0]);
				txLast     <= busIn[byteWidth-1:0];
				txCount    <= txLog.size();
				flags.tbre <= 1'b0;
				flags.tsre <= 1'b0;
				tbreDelay  <= 1 + $urandom_range(4);
				tsreDelay  <= 1 + $urandom_range(6);
			end else if (!flags.tbre) begin
				if (tbreDelay == 0) begin
					flags.tbre <= 1'b1;
				end else begin
					tbreDelay <= tbreDelay - 1;
				end
			end else if (!flags.tsre) begin
				if (tsreDelay == 0) begin
					flags.tsre <= 1'b1;
				end else begin
					tsreDelay <= tsreDelay - 1;
				end
			end
		end
	end

endmodule

// ==== testbench/memUartBridgeTb.sv ====
`timescale 1ns/1ps

module memUartBridgeTb
	import memBusPkg::*;
	import portCtrlPkg::*;
();

	localparam int sramPairs      = 24;
	localparam int uartWrites     = 6;
	localparam int uartReads      = 6;
	localparam int accessCount    = 2 * sramPairs + uartWrites + uartReads + 3;
	localparam int accessTimeout  = 200;
	localparam int watchdogCycles = accessTimeout * accessCount + 500;

	localparam sramCtrl sramIdleCtrl = '{en: 1'b1, oe: 1'b1, we: 1'b1};
	localparam uartCtrl uartIdleCtrl = '{rdn: 1'b1, wrn: 1'b1};

	typedef struct packed {
		logic   isRead;
		memWord value;
	} expectEntry;

	logic                 clk;
	logic                 rst;
	memReq                req;
	uartFlags             flags;
	memWord               busIn;
	memWord               busOut;
	logic                 busOe;
	memAddr               addr;
	sramCtrl              sram;
	uartCtrl              uart;
	memWord               result;
	logic                 done;
	logic                 rxPush;
	logic [byteWidth-1:0] rxByte;
	int                   txCount;
	logic [byteWidth-1:0] txLast;

	memWord               shadow [memAddr];
	logic [byteWidth-1:0] rxExpect[$];
	expectEntry           pending[$];
	int                   errors;
	int                   checks;
	int                   testsRun;
	int                   testStartErrors;
	logic                 donePrev;
	logic                 tsreDropped;
	logic                 tsreSeen;

	memUartBridge memUartBridge_inst (
		.clk    (clk),
		.rst    (rst),
		.req    (req),
		.flags  (flags),
		.busIn  (busIn),
		.busOut (busOut),
		.busOe  (busOe),
		.addr   (addr),
		.sram   (sram),
		.uart   (uart),
		.result (result),
		.done   (done)
	);

	busModels busModels_inst (
		.clk     (clk),
		.rst     (rst),
		.busOut  (busOut),
		.busOe   (busOe),
		.addr    (addr),
		.sram    (sram),
		.uart    (uart),
		.rxPush  (rxPush),
		.rxByte  (rxByte),
		.busIn   (busIn),
		.flags   (flags),
		.txCount (txCount),
		.txLast  (txLast)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Compare tasks and reference model
	//////////////////////////////////////////////////////////////////////

	task automatic checkWord(input string name, input memWord got, input memWord exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkAddr(input string name, input memAddr got, input memAddr exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkCtrl(input string name, input sramCtrl got, input sramCtrl exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic checkUartCtrl(input string name, input uartCtrl got, input uartCtrl exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic checkLevel(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic reportFailure(input string what);
		errors++;
		$display("t=%0t %s", $time, what);
	endtask

	// Write wins on the UART address, anything else defaults to read
	function automatic logic isReadReq(input memReq r);
		if (r.addr == uartAddr) begin
			return r.rd && !r.wr;
		end
		return !r.wr;
	endfunction

	function automatic memWord refResult(input memReq r);
		if (r.addr == uartAddr) begin
			return {{(dataWidth - byteWidth){1'b0}}, rxExpect[0]};
		end
		if (shadow.exists(r.addr)) begin
			return shadow[r.addr];
		end
		return '0;
	endfunction

	function automatic memAddr randomSramAddr();
		memAddr a;
		a = memAddr'($urandom);
		if (a == uartAddr) begin
			a = a ^ memAddr'(1);
		end
		return a;
	endfunction

	// Each rise of done retires the oldest accepted access
	always @(negedge clk) begin
		expectEntry entry;
		if (rst && done && !donePrev) begin
			if (pending.size() == 0) begin
				reportFailure("done rose with no access outstanding");
			end else begin
				entry = pending.pop_front();
				if (entry.isRead) begin
					checkWord("result", result, entry.value);
				end
			end
		end
		donePrev = done;
	end

	// Did tsre drop and come back after the last wrn pulse
	always @(negedge clk) begin
		if (!uart.wrn) begin
			tsreDropped = 1'b0;
			tsreSeen    = 1'b0;
		end else if (!flags.tsre) begin
			tsreDropped = 1'b1;
		end else if (tsreDropped) begin
			tsreSeen = 1'b1;
		end
	end

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, run stopped", watchdogCycles);
		$display("RESULT: FAIL");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic issue(input memReq r);
		@(negedge clk);
		req       = r;
		req.start = 1'b1;
		@(negedge clk);
		req.start = 1'b0;
	endtask

	task automatic waitDone(output int latency);
		latency = 0;
		while (!done && latency < accessTimeout) begin
			@(negedge clk);
			latency++;
		end
		if (!done) begin
			reportFailure("access timed out, done never rose");
		end
	endtask

	task automatic beginAccess(input memReq r);
		expectEntry entry;
		entry.isRead = isReadReq(r);
		entry.value  = entry.isRead ? refResult(r) : '0;
		pending.push_back(entry);
		issue(r);
	endtask

	task automatic finishAccess(input memReq r, output int latency);
		waitDone(latency);
		checkAddr("addr", addr, r.addr);
		if (r.addr != uartAddr && r.wr) begin
			shadow[r.addr] = r.value;
		end else if (r.addr == uartAddr && isReadReq(r)) begin
			void'(rxExpect.pop_front());
		end
	endtask

	task automatic runAccess(input memReq r, output int latency);
		beginAccess(r);
		finishAccess(r, latency);
	endtask

	// Competing start held for two cycles while the bridge is busy
	task automatic holdIgnored(input memReq r);
		req       = r;
		req.start = 1'b1;
		repeat (2) @(negedge clk);
		req = '0;
	endtask

	task automatic pushRx(input logic [byteWidth-1:0] b);
		@(negedge clk);
		rxByte = b;
		rxPush = 1'b1;
		rxExpect.push_back(b);
		@(negedge clk);
		rxPush = 1'b0;
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (errors == testStartErrors) begin
			$display("test %s passed", name);
		end else begin
			$display("test %s failed with %0d errors", name, errors - testStartErrors);
		end
		testStartErrors = errors;
	endtask

	initial begin
		memReq  r;
		memReq  other;
		memAddr addrs [sramPairs];
		int     latency;
		int     prevCount;
		int     rnd;
		void'($urandom(32'ha1d3be2e));
		errors          = 0;
		checks          = 0;
		testsRun        = 0;
		testStartErrors = 0;
		donePrev        = 1'b0;
		tsreDropped     = 1'b0;
		tsreSeen        = 1'b0;
		rst             = 1'b0;
		req             = '0;
		rxPush          = 1'b0;
		rxByte          = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		@(negedge clk);

		checkCtrl("sram", sram, sramIdleCtrl);
		checkUartCtrl("uart", uart, uartIdleCtrl);
		checkLevel("busOe", busOe, 1'b0);
		checkLevel("done", done, 1'b0);
		checkWord("result", result, '0);
		endTest("reset state");

		for (int i = 0; i < sramPairs; i++) begin
			addrs[i] = randomSramAddr();
			r        = '0;
			r.wr     = 1'b1;
			r.addr   = addrs[i];
			r.value  = memWord'($urandom);
			runAccess(r, latency);
			checkCount("sram write latency", latency, 4);
		end
		for (int i = 0; i < sramPairs; i++) begin
			r      = '0;
			r.rd   = 1'b1;
			r.addr = addrs[sramPairs - 1 - i];
			runAccess(r, latency);
			checkCount("sram read latency", latency, 4);
		end
		endTest("sram write and read");

		for (int i = 0; i < uartWrites; i++) begin
			r         = '0;
			r.wr      = 1'b1;
			r.rd      = i[0];
			r.addr    = uartAddr;
			r.value   = memWord'($urandom);
			prevCount = txCount;
			runAccess(r, latency);
			checkCount("txCount", txCount, prevCount + 1);
			checkWord("txLast", memWord'(txLast),
				{{(dataWidth - byteWidth){1'b0}}, r.value[byteWidth-1:0]});
			if (!tsreSeen) begin
				reportFailure("done rose before tsre was seen high again");
			end
		end
		endTest("uart write");

		for (int i = 0; i < uartReads; i++) begin
			rnd = $urandom;
			pushRx(rnd[byteWidth-1:0]);
			r       = '0;
			r.rd    = 1'b1;
			r.addr  = uartAddr;
			r.value = memWord'($urandom);
			runAccess(r, latency);
		end
		endTest("uart read");

		r       = '0;
		r.wr    = 1'b1;
		r.addr  = addrs[0];
		r.value = memWord'($urandom);
		beginAccess(r);
		other       = r;
		other.value = ~r.value;
		holdIgnored(other);
		finishAccess(r, latency);
		prevCount = txCount;
		r         = '0;
		r.rd      = 1'b1;
		r.addr    = addrs[0];
		beginAccess(r);
		other       = '0;
		other.wr    = 1'b1;
		other.addr  = uartAddr;
		other.value = memWord'($urandom);
		holdIgnored(other);
		finishAccess(r, latency);
		checkCount("txCount", txCount, prevCount);
		// UART address with neither strobe is dropped
		req       = '0;
		req.addr  = uartAddr;
		req.start = 1'b1;
		repeat (4) begin
			@(negedge clk);
			checkLevel("done", done, 1'b1);
			checkLevel("busOe", busOe, 1'b0);
			checkCtrl("sram", sram, sramIdleCtrl);
			checkUartCtrl("uart", uart, uartIdleCtrl);
		end
		req = '0;
		endTest("ignored requests");

		repeat (2) @(negedge clk);
		if (pending.size() != 0) begin
			reportFailure("accesses still outstanding at the end of the run");
		end
		$display("tests %0d, checks %0d, errors %0d", testsRun, checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
